/* common/cpuPkg.sv */
// Shared definitions for the five-stage RV32I subset core.
// Widths, opcodes, ALU codes, forwarding selects, ecall numbers and the
// instruction word views. Users refer to items as cpuPkg::name.
`default_nettype none

package cpuPkg;
    localparam int xlen = 32;
    localparam int regAddrW = 5;
    localparam int imemAddrW = 10;   // word addresses, byte address bits 11:2
    localparam int dmemAddrW = 10;

    localparam logic [6:0] opOp = 7'b0110011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal = 7'b1101111;
    localparam logic [6:0] opJalr = 7'b1100111;
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opSystem = 7'b1110011;

    localparam logic [31:0] nopInstr = 32'h0000_0013;   // addi x0, x0, 0

    localparam int aluOpW = 4;
    localparam logic [aluOpW-1:0] aluAdd = 4'd0;
    localparam logic [aluOpW-1:0] aluSub = 4'd1;
    localparam logic [aluOpW-1:0] aluAnd = 4'd2;
    localparam logic [aluOpW-1:0] aluOr = 4'd3;
    localparam logic [aluOpW-1:0] aluXor = 4'd4;
    localparam logic [aluOpW-1:0] aluSlt = 4'd5;

    localparam logic [1:0] fwdNone = 2'd0;
    localparam logic [1:0] fwdMem = 2'd1;
    localparam logic [1:0] fwdWb = 2'd2;

    // ecall reads a0 and a7, service 0x22 shows a0 on the LEDs
    localparam logic [regAddrW-1:0] regA0 = 5'd10;
    localparam logic [regAddrW-1:0] regA7 = 5'd17;
    localparam logic [xlen-1:0] ledService = 32'h22;

    typedef struct packed {
        logic [6:0] funct7;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0] funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0] opcode;
    } rFmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [regAddrW-1:0] rs1;
        logic [2:0] funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0] opcode;
    } iFmt_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFmt_t;

    typedef struct packed {
        logic imm12;
        logic [5:0] imm10to5;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic imm11;
        logic [6:0] opcode;
    } bFmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [regAddrW-1:0] rd;
        logic [6:0] opcode;
    } uFmt_t;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10to1;
        logic imm11;
        logic [7:0] imm19to12;
        logic [regAddrW-1:0] rd;
        logic [6:0] opcode;
    } jFmt_t;

    typedef union packed {
        rFmt_t r;
        iFmt_t i;
        sFmt_t s;
        bFmt_t b;
        uFmt_t u;
        jFmt_t j;
    } instrWord_t;
endpackage

`default_nettype wire

/* common/hazardIf.sv */
// Hazard bundle between the pipeline stages and the hazard unit.
// Decode reports its sources, execute and memory report their destinations,
// the hazard unit answers with forward selects, stall and flush.
`timescale 1ns/1ps
`default_nettype none

interface hazardIf;
    logic [cpuPkg::regAddrW-1:0] rs1;
    logic [cpuPkg::regAddrW-1:0] rs2;
    logic rs1Used;
    logic rs2Used;
    logic exRegWrite;
    logic [cpuPkg::regAddrW-1:0] exRd;
    logic exMemRead;
    logic memRegWrite;
    logic [cpuPkg::regAddrW-1:0] memRd;
    logic branchTaken;
    logic [1:0] fwdA;
    logic [1:0] fwdB;
    logic stall;
    logic flush;

    modport decode (output rs1, rs2, rs1Used, rs2Used, input stall, flush);
    modport execute (output exRegWrite, exRd, exMemRead, branchTaken, input fwdA, fwdB);
    modport mem (output memRegWrite, memRd);
    modport hazard (input rs1, rs2, rs1Used, rs2Used, exRegWrite, exRd, exMemRead,
                    memRegWrite, memRd, branchTaken, output fwdA, fwdB, stall, flush);
endinterface

`default_nettype wire

/* core/fetchStage.sv */
// Fetch stage. Holds the PC, the instruction memory and the IF/ID register.
// The memory is loaded through the imem write port while reset is held.
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  logic stall,
    input  logic flush,
    input  logic branchTaken,
    input  logic [cpuPkg::xlen-1:0] target,
    input  logic imemWe,
    input  logic [cpuPkg::imemAddrW-1:0] imemAddr,
    input  logic [cpuPkg::xlen-1:0] imemData,
    output logic [cpuPkg::xlen-1:0] idPc,
    output cpuPkg::instrWord_t idInstr
);
    logic [cpuPkg::xlen-1:0] imem [0:(1 << cpuPkg::imemAddrW)-1];
    logic [cpuPkg::xlen-1:0] pc;

    always_ff @(posedge clk) begin
        if (imemWe)
            imem[imemAddr] <= imemData;
    end

    always_ff @(posedge clk) begin
        if (rst)
            pc <= '0;
        else if (advance && !stall)
            pc <= branchTaken ? target : pc + 32'd4;   // taken target wins
    end

    always_ff @(posedge clk) begin
        if (rst || (advance && flush)) begin
            idInstr <= cpuPkg::nopInstr;   // wrong-path slot becomes a nop
            idPc <= '0;
        end else if (advance && !stall) begin
            idInstr <= imem[pc[cpuPkg::imemAddrW+1:2]];
            idPc <= pc;
        end
    end
endmodule

`default_nettype wire

/* core/decodeStage.sv */
// Decode stage. Decodes the instruction, reads the register file and
// selects the immediate, then loads the ID/EX register.
// Writeback writes the register file here and bypasses into the read.
// A stall or flush turns the ID/EX slot into a bubble.
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  logic [cpuPkg::xlen-1:0] idPc,
    input  cpuPkg::instrWord_t idInstr,
    input  logic wbRegWrite,
    input  logic [cpuPkg::regAddrW-1:0] wbRd,
    input  logic [cpuPkg::xlen-1:0] wbData,
    hazardIf.decode hz,
    output logic [cpuPkg::xlen-1:0] exPc,
    output cpuPkg::instrWord_t exInstr,
    output logic [cpuPkg::xlen-1:0] exRs1Val,
    output logic [cpuPkg::xlen-1:0] exRs2Val,
    output logic [cpuPkg::xlen-1:0] exImm,
    output logic [cpuPkg::aluOpW-1:0] exAluOp,
    output logic exAluSrcImm,
    output logic exRegWrite,
    output logic [cpuPkg::regAddrW-1:0] exRd,
    output logic exMemRead, exMemWrite, exBranchEq, exBranchNe,
    output logic exJal, exJalr, exLui, exEcall
);
    logic [cpuPkg::xlen-1:0] regs [0:31];
    logic [cpuPkg::xlen-1:0] imm;
    logic [cpuPkg::aluOpW-1:0] aluOp;
    logic aluSrcImm, regWrite, memRead, memWrite;
    logic branchEq, branchNe, jal, jalr, lui, ecall;
    logic bubble;

    function automatic logic [cpuPkg::aluOpW-1:0] funct3Op(input logic [2:0] f3,
                                                          input logic sub);
        case (f3)
            3'b111: return cpuPkg::aluAnd;
            3'b110: return cpuPkg::aluOr;
            3'b100: return cpuPkg::aluXor;
            3'b010: return cpuPkg::aluSlt;
            default: return sub ? cpuPkg::aluSub : cpuPkg::aluAdd;
        endcase
    endfunction

    function automatic logic [cpuPkg::xlen-1:0] readReg(input logic [cpuPkg::regAddrW-1:0] idx);
        if (idx == '0)
            return '0;
        if (wbRegWrite && wbRd == idx)
            return wbData;   // value retiring this cycle
        return regs[idx];
    endfunction

    always_comb begin
        {aluSrcImm, regWrite, memRead, memWrite, branchEq, branchNe} = '0;
        {jal, jalr, lui, ecall} = '0;
        aluOp = cpuPkg::aluAdd;
        hz.rs1 = idInstr.r.rs1;
        hz.rs2 = idInstr.r.rs2;
        {hz.rs1Used, hz.rs2Used} = 2'b00;
        imm = {{20{idInstr.i.imm[11]}}, idInstr.i.imm};
        case (idInstr.r.opcode)
            cpuPkg::opOp: begin
                regWrite = 1'b1;
                {hz.rs1Used, hz.rs2Used} = 2'b11;
                aluOp = funct3Op(idInstr.r.funct3, idInstr.r.funct7[5]);
            end
            cpuPkg::opOpImm: begin
                {regWrite, aluSrcImm, hz.rs1Used} = 3'b111;
                aluOp = funct3Op(idInstr.i.funct3, 1'b0);
            end
            cpuPkg::opLoad: {regWrite, memRead, aluSrcImm, hz.rs1Used} = 4'b1111;
            cpuPkg::opStore: begin
                {memWrite, aluSrcImm, hz.rs1Used, hz.rs2Used} = 4'b1111;
                imm = {{20{idInstr.s.immHi[6]}}, idInstr.s.immHi, idInstr.s.immLo};
            end
            cpuPkg::opBranch: begin
                branchEq = idInstr.b.funct3 == 3'b000;
                branchNe = idInstr.b.funct3 == 3'b001;
                {hz.rs1Used, hz.rs2Used} = 2'b11;
                imm = {{19{idInstr.b.imm12}}, idInstr.b.imm12, idInstr.b.imm11,
                       idInstr.b.imm10to5, idInstr.b.imm4to1, 1'b0};
            end
            cpuPkg::opJal: begin
                {regWrite, jal} = 2'b11;
                imm = {{11{idInstr.j.imm20}}, idInstr.j.imm20, idInstr.j.imm19to12,
                       idInstr.j.imm11, idInstr.j.imm10to1, 1'b0};
            end
            cpuPkg::opJalr: {regWrite, jalr, aluSrcImm, hz.rs1Used} = 4'b1111;
            cpuPkg::opLui: begin
                {regWrite, lui} = 2'b11;
                imm = {idInstr.u.imm, 12'b0};
            end
            cpuPkg::opSystem: begin
                ecall = idInstr.i.imm == '0 && idInstr.i.funct3 == '0;
                hz.rs1 = cpuPkg::regA0;   // ecall operands come from a0 and a7
                hz.rs2 = cpuPkg::regA7;
                {hz.rs1Used, hz.rs2Used} = 2'b11;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (advance && wbRegWrite && wbRd != '0)
            regs[wbRd] <= wbData;
    end

    assign bubble = hz.stall || hz.flush;

    always_ff @(posedge clk) begin
        if (rst || (advance && bubble)) begin
            {exRegWrite, exMemRead, exMemWrite, exBranchEq, exBranchNe} <= '0;
            {exJal, exJalr, exLui, exEcall} <= '0;
        end else if (advance) begin
            {exRegWrite, exMemRead, exMemWrite, exBranchEq, exBranchNe} <=
                {regWrite, memRead, memWrite, branchEq, branchNe};
            {exJal, exJalr, exLui, exEcall} <= {jal, jalr, lui, ecall};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            exPc <= idPc;
            exInstr <= idInstr;
            exRs1Val <= readReg(hz.rs1);
            exRs2Val <= readReg(hz.rs2);
            exImm <= imm;
            exAluOp <= aluOp;
            exAluSrcImm <= aluSrcImm;
            exRd <= idInstr.r.rd;
        end
    end
endmodule

`default_nettype wire

/* core/executeStage.sv */
// Execute stage. Picks forwarded operands, runs the ALU, resolves branches
// and jumps, and loads the EX/MEM register.
// Forward selects come from the hazard unit one cycle early and are held
// alongside the ID/EX slot they belong to.
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  logic [cpuPkg::xlen-1:0] exPc,
    input  cpuPkg::instrWord_t exInstr,
    input  logic [cpuPkg::xlen-1:0] exRs1Val,
    input  logic [cpuPkg::xlen-1:0] exRs2Val,
    input  logic [cpuPkg::xlen-1:0] exImm,
    input  logic [cpuPkg::aluOpW-1:0] exAluOp,
    input  logic exAluSrcImm,
    input  logic exRegWrite,
    input  logic [cpuPkg::regAddrW-1:0] exRd,
    input  logic exMemRead, exMemWrite, exBranchEq, exBranchNe,
    input  logic exJal, exJalr, exLui, exEcall,
    input  logic [cpuPkg::xlen-1:0] wbData,
    hazardIf.execute hz,
    output logic branchTaken,
    output logic [cpuPkg::xlen-1:0] target,
    output logic [cpuPkg::xlen-1:0] memResult,
    output logic [cpuPkg::xlen-1:0] memStoreData,
    output logic memRegWrite,
    output logic [cpuPkg::regAddrW-1:0] memRd,
    output logic memMemRead, memMemWrite, memEcall,
    output logic [cpuPkg::xlen-1:0] memA0,
    output logic [cpuPkg::xlen-1:0] memA7
);
    logic [1:0] fwdSelA, fwdSelB;
    logic [cpuPkg::xlen-1:0] opA, opB, aluB, aluOut, result;
    logic isJump;

    // memResult is this stage's own EX/MEM output, i.e. the memory-stage value
    function automatic logic [cpuPkg::xlen-1:0] pick(input logic [1:0] sel,
                                                    input logic [cpuPkg::xlen-1:0] regVal);
        case (sel)
            cpuPkg::fwdMem: return memResult;
            cpuPkg::fwdWb: return wbData;
            default: return regVal;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            fwdSelA <= cpuPkg::fwdNone;
            fwdSelB <= cpuPkg::fwdNone;
        end else if (advance) begin
            fwdSelA <= hz.fwdA;
            fwdSelB <= hz.fwdB;
        end
    end

    assign opA = pick(fwdSelA, exRs1Val);
    assign opB = pick(fwdSelB, exRs2Val);
    assign aluB = exAluSrcImm ? exImm : opB;

    always_comb begin
        case (exAluOp)
            cpuPkg::aluSub: aluOut = opA - aluB;
            cpuPkg::aluAnd: aluOut = opA & aluB;
            cpuPkg::aluOr: aluOut = opA | aluB;
            cpuPkg::aluXor: aluOut = opA ^ aluB;
            cpuPkg::aluSlt: aluOut = {{(cpuPkg::xlen-1){1'b0}}, $signed(opA) < $signed(aluB)};
            default: aluOut = opA + aluB;
        endcase
    end

    assign isJump = exJal || exJalr;
    assign branchTaken = isJump || (exBranchEq && opA == opB) || (exBranchNe && opA != opB);
    assign target = exJalr ? {aluOut[cpuPkg::xlen-1:1], 1'b0} : exPc + exImm;
    assign result = exLui ? exImm : (isJump ? exPc + 32'd4 : aluOut);   // link value for jumps

    assign hz.exRegWrite = exRegWrite;
    assign hz.exRd = exRd;
    assign hz.exMemRead = exMemRead;
    assign hz.branchTaken = branchTaken;

    always_ff @(posedge clk) begin
        if (rst) begin
            {memRegWrite, memMemRead, memMemWrite, memEcall} <= '0;
        end else if (advance) begin
            memRegWrite <= exRegWrite && exInstr.r.rd != '0;   // x0 writes die here
            memMemRead <= exMemRead;
            memMemWrite <= exMemWrite;
            memEcall <= exEcall;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            memResult <= result;
            memStoreData <= opB;
            memRd <= exRd;
            memA0 <= opA;
            memA7 <= opB;
        end
    end
endmodule

`default_nettype wire

/* core/memStage.sv */
// Memory stage. Word data memory with synchronous write and combinational
// read, followed by the MEM/WB register that holds the writeback value.
`timescale 1ns/1ps
`default_nettype none

module memStage (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  logic [cpuPkg::xlen-1:0] memResult,
    input  logic [cpuPkg::xlen-1:0] memStoreData,
    input  logic memRegWrite,
    input  logic [cpuPkg::regAddrW-1:0] memRd,
    input  logic memMemRead,
    input  logic memMemWrite,
    input  logic memEcall,
    input  logic [cpuPkg::xlen-1:0] memA0,
    input  logic [cpuPkg::xlen-1:0] memA7,
    hazardIf.mem hz,
    output logic wbRegWrite,
    output logic [cpuPkg::regAddrW-1:0] wbRd,
    output logic [cpuPkg::xlen-1:0] wbData,
    output logic wbEcall,
    output logic [cpuPkg::xlen-1:0] wbA0,
    output logic [cpuPkg::xlen-1:0] wbA7
);
    logic [cpuPkg::xlen-1:0] dmem [0:(1 << cpuPkg::dmemAddrW)-1];
    logic [cpuPkg::dmemAddrW-1:0] wordAddr;

    assign wordAddr = memResult[cpuPkg::dmemAddrW+1:2];
    assign hz.memRegWrite = memRegWrite;
    assign hz.memRd = memRd;

    always_ff @(posedge clk) begin
        if (memMemWrite && advance)
            dmem[wordAddr] <= memStoreData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbRegWrite <= 1'b0;
            wbEcall <= 1'b0;
        end else if (advance) begin
            wbRegWrite <= memRegWrite;
            wbEcall <= memEcall;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wbData <= memMemRead ? dmem[wordAddr] : memResult;   // load word or ALU result
            wbRd <= memRd;
            wbA0 <= memA0;
            wbA7 <= memA7;
        end
    end
endmodule

`default_nettype wire

/* hdl/hazardUnit.sv */
// Hazard unit, purely combinational.
// Forward selects are worked out against the decode sources, so they point
// at where the producer will sit once the consumer reaches execute.
// A load in execute feeding a decode source stalls one cycle, and a taken
// branch or jump flushes the younger stages.
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    hazardIf.hazard hz
);
    function automatic logic [1:0] fwdFor(input logic [cpuPkg::regAddrW-1:0] src,
                                          input logic used);
        if (!used || src == '0)
            return cpuPkg::fwdNone;
        if (hz.exRegWrite && hz.exRd == src)
            return cpuPkg::fwdMem;   // newest producer first
        if (hz.memRegWrite && hz.memRd == src)
            return cpuPkg::fwdWb;
        return cpuPkg::fwdNone;
    endfunction

    assign hz.fwdA = fwdFor(hz.rs1, hz.rs1Used);
    assign hz.fwdB = fwdFor(hz.rs2, hz.rs2Used);

    // load data is only ready after memory, one cycle too late to forward
    assign hz.stall = hz.exMemRead && hz.exRd != '0 &&
                      ((hz.rs1Used && hz.rs1 == hz.exRd) || (hz.rs2Used && hz.rs2 == hz.exRd));

    assign hz.flush = hz.branchTaken;
endmodule

`default_nettype wire

/* hdl/syscallUnit.sv */
// Ecall service at writeback.
// Service 0x22 in a7 copies a0 into the LED register. Any other ecall
// freezes the pipeline and raises halted until go grants one advance.
`timescale 1ns/1ps
`default_nettype none

module syscallUnit (
    input  logic clk,
    input  logic rst,
    input  logic go,
    input  logic wbEcall,
    input  logic [cpuPkg::xlen-1:0] wbA0,
    input  logic [cpuPkg::xlen-1:0] wbA7,
    output logic advance,
    output logic [cpuPkg::xlen-1:0] ledData,
    output logic halted
);
    logic ledCall;
    logic goGrant;

    assign ledCall = wbEcall && wbA7 == cpuPkg::ledService;
    assign halted = wbEcall && !ledCall;
    assign advance = !halted || goGrant;

    always_ff @(posedge clk) begin
        if (rst)
            goGrant <= 1'b0;
        else
            goGrant <= go && halted && !goGrant;   // single step past the ecall
    end

    always_ff @(posedge clk) begin
        if (rst)
            ledData <= '0;
        else if (ledCall)
            ledData <= wbA0;
    end
endmodule

`default_nettype wire

/* hdl/cpu.sv */
// Top level of the pipelined core.
// Connects fetch, decode, execute, memory, the hazard unit and the ecall
// service. The instruction memory is loaded through imemWe while rst is high.
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  logic clk,
    input  logic rst,
    input  logic go,
    input  logic imemWe,
    input  logic [cpuPkg::imemAddrW-1:0] imemAddr,
    input  logic [cpuPkg::xlen-1:0] imemData,
    output logic [cpuPkg::xlen-1:0] ledData,
    output logic halted
);
    hazardIf hz ();

    logic advance;
    logic branchTaken;
    logic [cpuPkg::xlen-1:0] target;
    logic [cpuPkg::xlen-1:0] idPc;
    cpuPkg::instrWord_t idInstr;
    cpuPkg::instrWord_t exInstr;
    logic [cpuPkg::xlen-1:0] exPc, exRs1Val, exRs2Val, exImm;
    logic [cpuPkg::aluOpW-1:0] exAluOp;
    logic [cpuPkg::regAddrW-1:0] exRd, memRd, wbRd;
    logic exAluSrcImm, exRegWrite, exMemRead, exMemWrite;
    logic exBranchEq, exBranchNe, exJal, exJalr, exLui, exEcall;
    logic [cpuPkg::xlen-1:0] memResult, memStoreData, memA0, memA7;
    logic memRegWrite, memMemRead, memMemWrite, memEcall;
    logic [cpuPkg::xlen-1:0] wbData, wbA0, wbA7;
    logic wbRegWrite, wbEcall;

    fetchStage fetch (
        .stall(hz.stall),
        .flush(hz.flush),
        .*
    );

    decodeStage decode (.*);

    executeStage execute (.*);

    memStage memory (.*);

    hazardUnit hazard (.hz(hz));

    syscallUnit syscall (.*);
endmodule

`default_nettype wire

/* dv/clockGen.sv */
// Testbench clock and reset source, 100 ns clock period.
// rst is high for the first 10 cycles, while holdReset is high, and for
// 10 cycles after holdReset drops. It only changes on falling edges.
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    input  logic holdReset,
    output logic clk,
    output logic rst
);
    localparam int resetCycles = 10;

    int resetLeft = resetCycles;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (holdReset)
            resetLeft <= resetCycles;   // restart the count
        else if (resetLeft != 0)
            resetLeft <= resetLeft - 1;
    end

    assign rst = holdReset || resetLeft != 0;
endmodule

`default_nettype wire

/* dv/cpuTb.sv */
// Testbench for the pipelined core.
// Programs, expected LED values and halt points come from dv/cpuCases.txt.
// Each program is written into the instruction memory while reset is held,
// then the LED register and halted are followed step by step.
// go is pulsed a random number of cycles after each halt but the last.
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
    localparam int caseWords = 1024;
    localparam int waitLimit = 500;   // cycles per wait
    localparam int ledStep = 1;
    localparam int haltStep = 2;

    logic clk, rst, holdReset, go, imemWe, halted;
    logic [cpuPkg::imemAddrW-1:0] imemAddr;
    logic [cpuPkg::xlen-1:0] imemData;
    logic [cpuPkg::xlen-1:0] ledData;
    logic [31:0] caseData [0:caseWords-1];
    logic [31:0] lastLed;
    int readPos = 0;
    int errors = 0;
    int checks = 0;
    int casesRun = 0;
    bit timedOut = 1'b0;

    clockGen clocks (.holdReset(holdReset), .clk(clk), .rst(rst));

    cpu dut (.clk(clk), .rst(rst), .go(go), .imemWe(imemWe), .imemAddr(imemAddr),
             .imemData(imemData), .ledData(ledData), .halted(halted));

    task automatic reportTimeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        errors++;
        timedOut = 1'b1;
    endtask

    task automatic loadProgram(input int first, input int loadAddr, input int count);
        int idx;
        int wordIndex;
        int waited;
        @(negedge clk);
        holdReset <= 1'b1;
        for (idx = 0; idx < count; idx++) begin
            @(negedge clk);
            wordIndex = loadAddr + idx;
            imemWe <= 1'b1;
            imemAddr <= wordIndex[cpuPkg::imemAddrW-1:0];
            imemData <= caseData[first + idx];
        end
        @(negedge clk);
        imemWe <= 1'b0;
        holdReset <= 1'b0;
        waited = 0;
        while (rst && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (rst)
            reportTimeout("reset to be released");
    endtask

    task automatic expectLed(input logic [31:0] expected);
        int waited;
        waited = 0;
        while (ledData == lastLed && !halted && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (ledData == lastLed && !halted) begin
            reportTimeout("an LED update");
            return;
        end
        checks++;
        assert (!halted && ledData == expected) else begin
            errors++;
            $display("Error: time %0t, LED %h with halted %b, expected LED %h",
                     $time, ledData, halted, expected);
        end
        lastLed = expected;
    endtask

    task automatic expectHalt(input bit lastStep);
        int waited;
        int holdCycles;
        waited = 0;
        while (ledData == lastLed && !halted && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (ledData == lastLed && !halted) begin
            reportTimeout("a halt");
            return;
        end
        checks++;
        assert (halted && ledData == lastLed) else begin
            errors++;
            $display("Error: time %0t, LED %h with halted %b, expected a halt with LED %h",
                     $time, ledData, halted, lastLed);
        end
        if (!halted || lastStep)
            return;
        holdCycles = 1 + $urandom % 8;
        repeat (holdCycles) begin
            @(negedge clk);
            checks++;
            assert (halted && ledData == lastLed) else begin
                errors++;
                $display("Error: time %0t, LED %h with halted %b while waiting for go",
                         $time, ledData, halted);
            end
        end
        go <= 1'b1;
        @(negedge clk);
        go <= 1'b0;
        waited = 0;
        while (halted && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (halted)
            reportTimeout("the core to resume after go");
    endtask

    task automatic runCase();
        int loadAddr;
        int wordCount;
        int stepCount;
        int step;
        int kind;
        logic [31:0] value;
        loadAddr = caseData[readPos];
        wordCount = caseData[readPos + 1];
        loadProgram(readPos + 2, loadAddr, wordCount);
        readPos = readPos + 2 + wordCount;
        stepCount = caseData[readPos];
        readPos++;
        lastLed = '0;   // LED register clears on reset
        if (!timedOut) begin
            checks++;
            assert (!halted && ledData == lastLed) else begin
                errors++;
                $display("Error: time %0t, LED %h with halted %b after reset, expected LED %h",
                         $time, ledData, halted, lastLed);
            end
        end
        for (step = 0; step < stepCount; step++) begin
            kind = caseData[readPos];
            value = caseData[readPos + 1];
            readPos += 2;
            if (!timedOut) begin
                if (kind == ledStep) begin
                    expectLed(value);
                end else if (kind == haltStep) begin
                    expectHalt(step == stepCount - 1);
                end else begin
                    $display("Unknown step kind %0d in the cases file", kind);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'h6756));
        holdReset = 1'b0;
        go = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        $readmemh("dv/cpuCases.txt", caseData);
        while (!timedOut && readPos + 1 < caseWords && caseData[readPos + 1] != '0) begin
            runCase();
            casesRun++;
        end
        if (casesRun == 0) begin
            $display("No test cases were read from the cases file");
            errors++;
        end
        $display("Cases run: %0d, checks: %0d, errors: %0d", casesRun, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end
endmodule

`default_nettype wire

/* dv/cpuCases.txt */
// per case: load word address, word count, the program words, then the step count
// and the steps as kind/value pairs (1 = expected LED value, 2 = halt with value 0)
// a word count of 0 ends the list

// ALU and immediate ops, LUI, back-to-back forwarding
0 1b
02200893 123452b7 6782e513 00000073 00c00313 00a00393 00730533 00000073
40750533 00000073 00737533 00000073 00736533 00000073 00734533 00000073
fff00e13 01c32533 00000073 006e2533 00000073 0063f513 00000073 ffd50513
00000073 05d00893 00000073
b
1 12345678 1 16 1 c 1 8 1 e 1 6 1 0 1 1 1 2 1 ffffffff 2 0

// stores, loads with immediate use, a halt released by go
0 17
02200893 05500293 00502023 abcde337 00602423 10000393 0063a223 00002503
00000073 00802503 00000073 05d00893 00000073 02200893 0043ae03 001e0513
00000073 00a02023 00002503 00150513 00000073 05d00893 00000073
6
1 55 1 abcde000 2 0 1 abcde001 1 abcde002 2 0

// taken BEQ, BNE, JAL, JALR with wrong-path LED ecalls of 0x666
0 1c
02200893 00700293 00700313 00628663 66600513 00000073 00100513 00000073
00629463 00200513 00000073 00300313 00629663 66600513 00000073 00c000ef
66600513 00000073 00008513 00000073 06000393 001380e7 66600513 00000073
00008513 00000073 05d00893 00000073
5
1 1 1 2 1 40 1 58 2 0

0 0

/* cpu.f */
common/cpuPkg.sv
common/hazardIf.sv
core/fetchStage.sv
core/decodeStage.sv
core/executeStage.sv
core/memStage.sv
hdl/hazardUnit.sv
hdl/syscallUnit.sv
hdl/cpu.sv
dv/clockGen.sv
dv/cpuTb.sv

/* Makefile */
# Verilator flow for the pipelined core and its testbench.
# make lint checks the RTL, make sim builds and runs the testbench,
# make clean removes the build output and the log.

BUILD = obj_dir
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f cpu.f --top-module cpu

sim:
	verilator --binary --timing --assert -f cpu.f --top-module cpuTb --Mdir $(BUILD) -o simv
	./$(BUILD)/simv | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
